/* source/armCtrl_settings.svh */
`ifndef ARM_CTRL_SETTINGS_SVH
`define ARM_CTRL_SETTINGS_SVH

// Datapath widths
`define ARM_INSTR_W 32 // Instruction word
`define ARM_FLAGS_W 4  // N Z C V

// ALU opcodes used outside data processing
`define ARM_OP_ADD 4'b0100 // Loads and stores with U set, branches
`define ARM_OP_SUB 4'b0010 // Loads and stores with U clear

// Register file
`define ARM_REG_PC 4'd15 // Destination that redirects the fetch

`endif

/* source/armCtrlPkg.sv */
`default_nettype none

package armCtrlPkg;

  // ========================================
  // Data processing opcodes, instr[24:21]
  typedef enum logic [3:0] {
    opAnd, opEor, opSub, opRsb, opAdd, opAdc, opSbc, opRsc,
    opTst, opTeq, opCmp, opCmn, opOrr, opMov, opBic, opMvn
  } aluOpT;

  // Condition field, instr[31:28]
  typedef enum logic [3:0] {
    condEq, condNe, condCs, condCc, condMi, condPl, condVs, condVc,
    condHi, condLs, condGe, condLt, condGt, condLe, condAl, condNv
  } condT;

  typedef struct packed {
    logic n; // Negative
    logic z; // Zero
    logic c; // Carry
    logic v; // Overflow
  } flagsT;

  typedef logic [1:0] flagWriteT; // [1] updates N Z, [0] updates C V

  // ========================================
  // Control word carried down the pipe
  typedef struct packed {
    logic      regWrite;
    logic      memWrite;
    logic      memtoReg;   // Result comes from data memory
    logic      branch;
    logic      pcSrc;      // Writes the PC
    logic      aluSrc;     // Immediate operand B
    logic      byteAccess; // LDRB / STRB
    aluOpT     aluControl;
    flagWriteT flagWrite;
    logic      noRegWrite; // TST TEQ CMP CMN
    condT      cond;
  } stageCtrlT;

endpackage

`default_nettype wire

/* source/stageCtrlIf.sv */
`timescale 1ns/10ps
`default_nettype none

// Control word handed from one stage to the next
interface stageCtrlIf;
  import armCtrlPkg::*;

  stageCtrlT ctrl;      // Control word of the instruction
  logic      setFlags;  // Instruction updates the status flags
  flagsT     flagsNext; // Flags it will write
  logic      valid;     // Kept instruction in the stage

  // Upstream stage drives
  modport sender (
    output ctrl,
    output setFlags,
    output flagsNext,
    output valid
  );

  // Downstream stage reads
  modport receiver (
    input ctrl,
    input setFlags,
    input flagsNext,
    input valid
  );

endinterface

`default_nettype wire

/* source/instrDecoder.sv */
`timescale 1ns/10ps
`default_nettype none
`include "armCtrl_settings.svh"

module instrDecoder (
  input  wire logic [`ARM_INSTR_W-1:0] instr,
  output logic      [1:0]              regSrc,
  output logic      [1:0]              immSrc,
  output logic                         aluSrc,
  stageCtrlIf.sender                   decodeOut
);
  import armCtrlPkg::*;

  logic      isDp, isLdSt, isBranch, kept;
  logic      memtoReg, regWrite, memWrite, branch;
  aluOpT     aluControl;
  flagWriteT flagWrite;
  logic      noRegWrite, logicalOp, writesPc;
  stageCtrlT ctrl;

  // ========================================
  // Instruction groups

  // Data processing, leaving out MSR/MRS/BX/CLZ and the extra load/store and multiply space
  assign isDp     = (instr[27:26] == 2'b00) & ~((instr[24:23] == 2'b10) & ~instr[20])
                    & (instr[25] | ~instr[4]);
  assign isLdSt   = (instr[27:26] == 2'b01) & ~(instr[25] & instr[4]); // Skip undefined space
  assign isBranch = (instr[27:25] == 3'b101) & ~instr[24];              // B only, no link
  assign kept     = isDp | isLdSt | isBranch;

  // Main decoder
  always_comb begin
    regSrc   = 2'b00;
    immSrc   = 2'b00;
    aluSrc   = 1'b0;
    memtoReg = 1'b0;
    regWrite = 1'b0;
    memWrite = 1'b0;
    branch   = 1'b0;
    if (isDp) begin
      regWrite = 1'b1;
      aluSrc   = instr[25];   // Immediate form
    end else if (isLdSt) begin
      immSrc = 2'b01;         // 12-bit offset
      aluSrc = 1'b1;
      if (instr[20]) begin    // LDR
        regWrite = 1'b1;
        memtoReg = 1'b1;
      end else begin          // STR reads Rd as store data
        memWrite = 1'b1;
        regSrc   = 2'b10;
      end
    end else if (isBranch) begin
      branch = 1'b1;
      immSrc = 2'b10;         // 24-bit word offset
      regSrc = 2'b01;         // PC as operand A
      aluSrc = 1'b1;
    end
  end

  // ========================================
  // ALU decoder
  assign logicalOp = aluOpT'(instr[24:21]) inside {opAnd, opEor, opTst, opTeq,
                                                   opOrr, opMov, opBic, opMvn};

  always_comb begin
    aluControl = opAnd; // All-zero word for dropped forms
    flagWrite  = 2'b00;
    noRegWrite = 1'b0;
    if (isLdSt) begin
      aluControl = aluOpT'(instr[23] ? `ARM_OP_ADD : `ARM_OP_SUB); // U bit
    end else if (isDp) begin
      aluControl = aluOpT'(instr[24:21]);
      if (instr[20])
        flagWrite = logicalOp ? 2'b10 : 2'b11; // Logical ops leave C V to the shifter
      noRegWrite = (instr[24:23] == 2'b10);    // Compare group
    end else if (isBranch) begin
      aluControl = aluOpT'(`ARM_OP_ADD);       // PC + offset
    end
  end

  assign writesPc = regWrite & ~noRegWrite & (instr[15:12] == `ARM_REG_PC);

  // Pack the control word
  always_comb begin
    ctrl            = '0;
    ctrl.regWrite   = regWrite;
    ctrl.memWrite   = memWrite;
    ctrl.memtoReg   = memtoReg;
    ctrl.branch     = branch;
    ctrl.pcSrc      = branch | writesPc;
    ctrl.aluSrc     = aluSrc;
    ctrl.byteAccess = isLdSt & instr[22];
    ctrl.aluControl = aluControl;
    ctrl.flagWrite  = flagWrite;
    ctrl.noRegWrite = noRegWrite;
    ctrl.cond       = kept ? condT'(instr[31:28]) : condEq;
  end

  assign decodeOut.ctrl      = ctrl;
  assign decodeOut.setFlags  = 1'b0; // Not known before execute
  assign decodeOut.flagsNext = '0;
  assign decodeOut.valid     = kept;

endmodule

`default_nettype wire

/* source/executeCtrl.sv */
`timescale 1ns/10ps
`default_nettype none

module executeCtrl (
  input  wire logic              clk,
  input  wire logic              rstN,
  input  wire logic              stallE,
  input  wire logic              flushE,
  input  wire armCtrlPkg::flagsT aluFlagsE,
  stageCtrlIf.receiver           decodeIn,
  stageCtrlIf.sender             execOut,
  input  wire armCtrlPkg::flagsT flagsFwdM,
  input  wire armCtrlPkg::flagsT flagsFwdW,
  input  wire logic              setFlagsM,
  input  wire logic              setFlagsW,
  input  wire armCtrlPkg::flagsT flagsW,
  output armCtrlPkg::aluOpT      aluControlE,
  output logic                   aluSrcE,
  output logic                   branchTakenE,
  output armCtrlPkg::flagsT      flagsE
);
  import armCtrlPkg::*;

  stageCtrlT ctrlE;     // D-to-E register
  logic      validE;
  logic      condExE;   // Condition passed
  stageCtrlT ctrlGated;
  flagsT     nextFlags;

  // Standard ARM condition table
  function automatic logic condCheck(input condT cond, input flagsT f);
    logic pass;
    case (cond)
      condEq:  pass = f.z;
      condNe:  pass = ~f.z;
      condCs:  pass = f.c;
      condCc:  pass = ~f.c;
      condMi:  pass = f.n;
      condPl:  pass = ~f.n;
      condVs:  pass = f.v;
      condVc:  pass = ~f.v;
      condHi:  pass = f.c & ~f.z;
      condLs:  pass = ~f.c | f.z;
      condGe:  pass = (f.n == f.v);
      condLt:  pass = (f.n != f.v);
      condGt:  pass = ~f.z & (f.n == f.v);
      condLe:  pass = f.z | (f.n != f.v);
      condAl:  pass = 1'b1;
      default: pass = 1'b0; // NV never executes
    endcase
    return pass;
  endfunction

  // ========================================
  // Stage register
  always_ff @(posedge clk) begin
    if (!rstN || flushE) begin // Flush wins over stall
      ctrlE  <= '0;
      validE <= 1'b0;
    end else if (!stallE) begin
      ctrlE  <= decodeIn.ctrl;
      validE <= decodeIn.valid;
    end
  end

  // Newest flags in flight, M ahead of W ahead of the status register
  assign flagsE = setFlagsM ? flagsFwdM :
                  setFlagsW ? flagsFwdW : flagsW;

  assign condExE = validE & condCheck(ctrlE.cond, flagsE);

  // ========================================
  // Gate the writes by the condition
  always_comb begin
    ctrlGated          = ctrlE;
    ctrlGated.regWrite = ctrlE.regWrite & condExE & ~ctrlE.noRegWrite;
    ctrlGated.memWrite = ctrlE.memWrite & condExE;
    ctrlGated.pcSrc    = ctrlE.pcSrc & condExE;
    ctrlGated.branch   = ctrlE.branch & condExE;
  end

  // Merge ALU flags into the current ones under flagWrite
  always_comb begin
    nextFlags   = flagsE;
    if (ctrlE.flagWrite[1]) begin
      nextFlags.n = aluFlagsE.n;
      nextFlags.z = aluFlagsE.z;
    end
    if (ctrlE.flagWrite[0]) begin
      nextFlags.c = aluFlagsE.c;
      nextFlags.v = aluFlagsE.v;
    end
  end

  assign execOut.ctrl      = ctrlGated;
  assign execOut.setFlags  = (ctrlE.flagWrite != 2'b00) & condExE;
  assign execOut.flagsNext = nextFlags;
  assign execOut.valid     = validE;

  assign aluControlE  = ctrlE.aluControl;
  assign aluSrcE      = ctrlE.aluSrc;
  assign branchTakenE = ctrlGated.branch; // Combinational on E register and flags

endmodule

`default_nettype wire

/* source/memWbCtrl.sv */
`timescale 1ns/10ps
`default_nettype none

module memWbCtrl (
  input  wire logic         clk,
  input  wire logic         rstN,
  input  wire logic         stallM,
  input  wire logic         flushM,
  input  wire logic         stallW,
  input  wire logic         flushW,
  stageCtrlIf.receiver      execIn,
  output logic              memWriteM,
  output logic              memtoRegM,
  output logic              regWriteM,
  output logic              byteM,
  output logic              memtoRegW,
  output logic              regWriteW,
  output logic              pcSrcW,
  output armCtrlPkg::flagsT flagsFwdM,
  output armCtrlPkg::flagsT flagsFwdW,
  output logic              setFlagsM,
  output logic              setFlagsW,
  output armCtrlPkg::flagsT flagsW
);
  import armCtrlPkg::*;

  stageCtrlT ctrlM; // E-to-M register

  // ========================================
  // Memory stage
  always_ff @(posedge clk) begin
    if (!rstN || flushM) begin
      ctrlM     <= '0;
      setFlagsM <= 1'b0;
      flagsFwdM <= '0;
    end else if (!stallM) begin
      ctrlM     <= execIn.ctrl;
      setFlagsM <= execIn.setFlags;
      flagsFwdM <= execIn.flagsNext;
    end
  end

  assign memWriteM = ctrlM.memWrite;
  assign memtoRegM = ctrlM.memtoReg;
  assign regWriteM = ctrlM.regWrite;  // Also seen by the hazard unit
  assign byteM     = ctrlM.byteAccess;

  // ========================================
  // Writeback stage
  always_ff @(posedge clk) begin
    if (!rstN || flushW) begin
      memtoRegW <= 1'b0;
      regWriteW <= 1'b0;
      pcSrcW    <= 1'b0;
      setFlagsW <= 1'b0;
      flagsFwdW <= '0;
    end else if (!stallW) begin
      memtoRegW <= ctrlM.memtoReg;
      regWriteW <= ctrlM.regWrite;
      pcSrcW    <= ctrlM.pcSrc;
      setFlagsW <= setFlagsM;
      flagsFwdW <= flagsFwdM;
    end
  end

  // Status flags, written as the instruction leaves W
  always_ff @(posedge clk) begin
    if (!rstN)
      flagsW <= '0;
    else if (setFlagsW && !stallW)
      flagsW <= flagsFwdW;
  end

endmodule

`default_nettype wire

/* source/armController.sv */
`timescale 1ns/10ps
`default_nettype none
`include "armCtrl_settings.svh"

module armController (
  input  wire logic [`ARM_INSTR_W-1:0] instrD,
  input  wire logic                    clk,
  input  wire logic                    rstN,
  input  wire logic [`ARM_FLAGS_W-1:0] aluFlagsE,
  input  wire logic                    stallE,
  input  wire logic                    flushE,
  input  wire logic                    stallM,
  input  wire logic                    flushM,
  input  wire logic                    stallW,
  input  wire logic                    flushW,
  output logic      [1:0]              regSrcD,
  output logic      [1:0]              immSrcD,
  output logic                         aluSrcD,
  output armCtrlPkg::aluOpT            aluControlE,
  output logic                         aluSrcE,
  output logic                         branchTakenE,
  output logic      [`ARM_FLAGS_W-1:0] flagsE,
  output logic                         memWriteM,
  output logic                         memtoRegM,
  output logic                         regWriteM,
  output logic                         byteM,
  output logic                         memtoRegW,
  output logic                         regWriteW,
  output logic                         pcSrcW,
  output logic      [`ARM_FLAGS_W-1:0] flagsW
);
  import armCtrlPkg::*;

  flagsT flagsFwdM, flagsFwdW; // Flags in flight back to execute
  logic  setFlagsM, setFlagsW;

  stageCtrlIf decodeToExec ();
  stageCtrlIf execToMem ();

  // ========================================
  instrDecoder uDecoder (
    .instr     (instrD),
    .regSrc    (regSrcD),
    .immSrc    (immSrcD),
    .aluSrc    (aluSrcD),
    .decodeOut (decodeToExec.sender)
  );

  executeCtrl uExecute (
    .clk          (clk),
    .rstN         (rstN),
    .stallE       (stallE),
    .flushE       (flushE),
    .aluFlagsE    (aluFlagsE),
    .decodeIn     (decodeToExec.receiver),
    .execOut      (execToMem.sender),
    .flagsFwdM    (flagsFwdM),
    .flagsFwdW    (flagsFwdW),
    .setFlagsM    (setFlagsM),
    .setFlagsW    (setFlagsW),
    .flagsW       (flagsW),
    .aluControlE  (aluControlE),
    .aluSrcE      (aluSrcE),
    .branchTakenE (branchTakenE),
    .flagsE       (flagsE)
  );

  memWbCtrl uMemWb (
    .clk       (clk),
    .rstN      (rstN),
    .stallM    (stallM),
    .flushM    (flushM),
    .stallW    (stallW),
    .flushW    (flushW),
    .execIn    (execToMem.receiver),
    .memWriteM (memWriteM),
    .memtoRegM (memtoRegM),
    .regWriteM (regWriteM),
    .byteM     (byteM),
    .memtoRegW (memtoRegW),
    .regWriteW (regWriteW),
    .pcSrcW    (pcSrcW),
    .flagsFwdM (flagsFwdM),
    .flagsFwdW (flagsFwdW),
    .setFlagsM (setFlagsM),
    .setFlagsW (setFlagsW),
    .flagsW    (flagsW)
  );

endmodule

`default_nettype wire

/* tests/armControllerTb.sv */
`timescale 1ns/10ps
`default_nettype none
`include "armCtrl_settings.svh"

module armControllerTb;

  localparam int clkPeriod     = 100;
  localparam int resetCycles   = 4;
  localparam int maxLines      = 64;  // Upper bound for the replay loop
  localparam int fieldsPerLine = 13;
  localparam int memWords      = 1 + maxLines * fieldsPerLine; // Word 0 holds the line count

  // Expected side-band controls of one stage
  typedef struct packed {
    logic aluSrc;
    logic memtoReg;
    logic byteAcc;
    logic setsFlags; // S bit seen, flags may be in flight
  } stageExpT;

  logic [31:0] stimMem [0:memWords-1];

  logic                    clk;
  logic                    rstN;
  logic [`ARM_INSTR_W-1:0] instrD;
  logic [`ARM_FLAGS_W-1:0] aluFlagsE;
  logic                    stallE, flushE, stallM, flushM, stallW, flushW;
  logic [1:0]              regSrcD, immSrcD;
  logic                    aluSrcD, aluSrcE, branchTakenE;
  logic [3:0]              aluControlE;
  logic [`ARM_FLAGS_W-1:0] flagsE, flagsW;
  logic                    memWriteM, memtoRegM, regWriteM, byteM;
  logic                    memtoRegW, regWriteW, pcSrcW;
  int                      lineCount;
  stageExpT                expE, expM, expW;
  logic                    prevRegWriteM; // regWriteM seen on the previous line

  armController u_dut (
    .instrD       (instrD),
    .clk          (clk),
    .rstN         (rstN),
    .aluFlagsE    (aluFlagsE),
    .stallE       (stallE),
    .flushE       (flushE),
    .stallM       (stallM),
    .flushM       (flushM),
    .stallW       (stallW),
    .flushW       (flushW),
    .regSrcD      (regSrcD),
    .immSrcD      (immSrcD),
    .aluSrcD      (aluSrcD),
    .aluControlE  (aluControlE),
    .aluSrcE      (aluSrcE),
    .branchTakenE (branchTakenE),
    .flagsE       (flagsE),
    .memWriteM    (memWriteM),
    .memtoRegM    (memtoRegM),
    .regWriteM    (regWriteM),
    .byteM        (byteM),
    .memtoRegW    (memtoRegW),
    .regWriteW    (regWriteW),
    .pcSrcW       (pcSrcW),
    .flagsW       (flagsW)
  );

  always #(clkPeriod / 2) clk = ~clk;

  // ========================================
  // Helpers
  task automatic abortRun();
    $display("TEST FAILED");
    $fatal(1);
  endtask

  function automatic string behaviorName(input logic [31:0] id);
    case (id)
      32'd1:   return "reset";
      32'd2:   return "decode";
      32'd3:   return "latency";
      32'd4:   return "conditions";
      32'd5:   return "compare";
      32'd6:   return "stallFlush";
      default: return "unknown";
    endcase
  endfunction

  task automatic checkValue(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    assert (actual === expected) else begin
      $display("Error: %s expected %0h actual %0h", name, expected, actual);
      abortRun();
    end
  endtask

  task automatic driveLine(input int base);
    logic [3:0] stallFlush;
    stallFlush = stimMem[base+3][3:0]; // {stallW, stallM, stallE, flushE}
    instrD     = stimMem[base+1];
    aluFlagsE  = stimMem[base+2][3:0]; // Flags of the instruction now in E
    stallW     = stallFlush[3];
    stallM     = stallFlush[2];
    stallE     = stallFlush[1];
    flushE     = stallFlush[0];
    flushM     = 1'b0;
    flushW     = 1'b0;
  endtask

  // Moves the expected controls down the pipe at the coming rising edge
  task automatic advanceModel(input int base);
    stageExpT    dExp;
    logic [3:0]  stallFlush;
    logic [31:0] instr;
    logic        ldSt;
    stallFlush     = stimMem[base+3][3:0];
    instr          = stimMem[base+1];
    ldSt           = (stimMem[base+5] == 32'd1); // Only loads and stores take the 12-bit offset
    dExp.aluSrc    = stimMem[base+6][0];
    dExp.memtoReg  = ldSt & (stimMem[base+4] == 32'd0); // LDR reads no store data
    dExp.byteAcc   = ldSt & instr[22];
    dExp.setsFlags = (instr[27:26] == 2'b00) & instr[20];
    if (!stallFlush[3])
      expW = expM;
    if (!stallFlush[2])
      expM = expE;
    if (stallFlush[0])
      expE = '0; // Flush wins over stall
    else if (!stallFlush[1])
      expE = dExp;
  endtask

  task automatic checkLine(input int base, input int lineNo);
    string tag;
    tag = $sformatf("%s line %0d", behaviorName(stimMem[base]), lineNo);
    checkValue({tag, " regSrcD"}, stimMem[base+4], 32'(regSrcD));
    checkValue({tag, " immSrcD"}, stimMem[base+5], 32'(immSrcD));
    checkValue({tag, " aluSrcD"}, stimMem[base+6], 32'(aluSrcD));
    checkValue({tag, " aluControlE"}, stimMem[base+7], 32'(aluControlE));
    checkValue({tag, " branchTakenE"}, stimMem[base+8], 32'(branchTakenE));
    checkValue({tag, " memWriteM"}, stimMem[base+9], 32'(memWriteM));
    checkValue({tag, " regWriteW"}, stimMem[base+10], 32'(regWriteW));
    checkValue({tag, " pcSrcW"}, stimMem[base+11], 32'(pcSrcW));
    checkValue({tag, " flagsE"}, stimMem[base+12], 32'(flagsE));
    checkValue({tag, " aluSrcE"}, 32'(expE.aluSrc), 32'(aluSrcE));
    checkValue({tag, " memtoRegM"}, 32'(expM.memtoReg), 32'(memtoRegM));
    checkValue({tag, " byteM"}, 32'(expM.byteAcc), 32'(byteM));
    checkValue({tag, " memtoRegW"}, 32'(expW.memtoReg), 32'(memtoRegW));
    // Nothing in flight, so the status register is what execute sees
    if (!expM.setsFlags && !expW.setsFlags)
      checkValue({tag, " flagsW"}, stimMem[base+12], 32'(flagsW));
    // W took the word that M held one line earlier
    if (lineNo > 1 && !stallW)
      checkValue({tag, " regWriteM"}, stimMem[base+10], 32'(prevRegWriteM));
    prevRegWriteM = regWriteM;
  endtask

  task automatic applyReset();
    rstN = 1'b0;
    repeat (resetCycles) @(posedge clk);
    @(negedge clk);
    rstN = 1'b1; // Released on a falling edge
  endtask

  // ========================================
  // Replay the stimulus file, one line per cycle
  initial begin
    int base;
    clk           = 1'b0;
    rstN          = 1'b0;
    instrD        = '0;
    aluFlagsE     = '0;
    stallE        = 1'b0;
    flushE        = 1'b0;
    stallM        = 1'b0;
    flushM        = 1'b0;
    stallW        = 1'b0;
    flushW        = 1'b0;
    expE          = '0;
    expM          = '0;
    expW          = '0;
    prevRegWriteM = 1'b0;
    $readmemh("tests/armController_stimulus.txt", stimMem);
    lineCount = stimMem[0];
    if (lineCount > maxLines) begin
      $display("Stimulus file holds more lines than the replay loop allows");
      abortRun();
    end
    applyReset();
    for (int i = 0; i < lineCount && i < maxLines; i++) begin
      base = 1 + i * fieldsPerLine;
      driveLine(base);
      advanceModel(base);
      @(posedge clk);
      #(clkPeriod / 2 - 10); // Just before the next falling edge
      checkLine(base, i + 1);
      @(negedge clk);
    end
    if (lineCount == 0) begin
      $display("Stimulus file holds no lines to replay");
      abortRun();
    end else begin
      $display("TEST PASSED");
      $finish;
    end
  end

  // Watchdog
  initial begin
    #(clkPeriod * (resetCycles + maxLines + 8));
    $display("Timeout: the replay did not finish in time");
    abortRun();
  end

endmodule

`default_nettype wire

/* tests/armController_stimulus.txt */
// Columns: test instrD aluFlagsE stallFlush(stallW,stallM,stallE,flushE) | expected
// regSrcD immSrcD aluSrcD aluControlE branchTakenE memWriteM regWriteW pcSrcW flagsE
00000012 // Number of lines, hex
1 E10F0000 0 0  0 0 0 0 0 0 0 0 0 // Bubble after reset
2 E0821003 0 0  0 0 0 4 0 0 0 0 0 // ADD r1,r2,r3
2 E2454001 0 0  0 0 1 2 0 0 0 0 0 // SUB r4,r5,#1
3 E5976004 0 0  0 1 1 4 0 0 1 0 0 // LDR r6,[r7,#4], ADD in W
3 E5098008 0 0  2 1 1 2 0 0 1 0 0 // STR r8,[r9,#-8]
3 EA000010 0 0  1 2 1 4 1 1 1 0 0 // B, STR in M
4 E0510001 0 0  0 0 0 2 0 0 0 0 0 // SUBS r0,r1,r1
4 0A000004 6 0  1 2 1 4 1 0 0 1 6 // BEQ, Z forwarded from M
4 12822001 0 0  0 0 1 4 0 0 1 0 6 // ADDNE r2,r2,#1
4 E3530005 0 0  0 0 1 A 0 0 0 1 6 // CMP r3,#5, BEQ pcSrc in W
5 E1A0F000 8 0  0 0 0 D 0 0 0 0 8 // MOV pc,r0, ADDNE writes nothing
5 E1855006 0 0  0 0 0 C 0 0 0 0 8 // ORR r5,r5,r6, CMP writes nothing
6 E0821003 0 E  0 0 0 C 0 0 0 0 8 // Stall, ORR held in E
6 E0821003 0 0  0 0 0 4 0 0 1 1 8 // ADD released, MOV pc in W
6 E5098008 0 1  2 1 1 0 0 0 1 0 8 // STR flushed from E
6 E10F0000 0 0  0 0 0 0 0 0 1 0 8 // No memWriteM from the STR
6 E10F0000 0 0  0 0 0 0 0 0 0 0 8
6 E10F0000 0 0  0 0 0 0 0 0 0 0 8

/* sim.f */
+incdir+source
source/armCtrlPkg.sv
source/stageCtrlIf.sv
source/instrDecoder.sv
source/executeCtrl.sv
source/memWbCtrl.sv
source/armController.sv
tests/armControllerTb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the armController testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert -j 0 --top-module armControllerTb -f sim.f
./obj_dir/VarmControllerTb
